/* all.f */
src/warp_arch_pkg.sv
src/warp_uop_pkg.sv
src/warp_issue.sv
src/warp_xrf.sv
src/warp_xarith.sv
src/warp_xlogic.sv
src/warp_backend.sv
test/tb_warp_backend.sv

/* src/warp_arch_pkg.sv */
package warp_arch_pkg;

    // data path width of the integer registers
    localparam int XLEN = 64;

    // architectural register count, x0 included
    localparam int NUM_REGS = 32;

    // bits needed to name one register
    localparam int REG_ADDR_W = 5;

    // one register value
    typedef logic [XLEN-1:0] xdata_t;

    // register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one bit per register, used for busy and retire masks
    typedef logic [NUM_REGS-1:0] reg_mask_t;

endpackage

/* src/warp_backend.sv */
`timescale 1ns/1ps

module warp_backend
    import warp_arch_pkg::*, warp_uop_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    output logic            o_ready,
    input  unit_sel_t       i_unit,
    input  logic [OP_W-1:0] i_op,
    input  reg_addr_t       i_rd,
    input  reg_addr_t       i_rs1,
    input  reg_addr_t       i_rs2,
    input  logic            i_use_imm,
    input  xdata_t          i_imm,
    output logic            o_wb0_valid,
    output reg_addr_t       o_wb0_rd,
    output xdata_t          o_wb0_data,
    output logic            o_wb1_valid,
    output reg_addr_t       o_wb1_rd,
    output xdata_t          o_wb1_data
);
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    xdata_t          rs1_rdata;
    xdata_t          rs2_rdata;
    logic            arith_valid;
    logic            logic_valid;
    logic [OP_W-1:0] disp_op;
    reg_addr_t       disp_rd;
    logic            disp_use_imm;
    xdata_t          disp_imm;

    warp_issue issue (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_unit       (i_unit),
        .i_op         (i_op),
        .i_rd         (i_rd),
        .i_rs1        (i_rs1),
        .i_rs2        (i_rs2),
        .i_use_imm    (i_use_imm),
        .i_imm        (i_imm),
        .i_wb0_valid  (o_wb0_valid),
        .i_wb0_rd     (o_wb0_rd),
        .i_wb1_valid  (o_wb1_valid),
        .i_wb1_rd     (o_wb1_rd),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_arith_valid(arith_valid),
        .o_logic_valid(logic_valid),
        .o_op         (disp_op),
        .o_rd         (disp_rd),
        .o_use_imm    (disp_use_imm),
        .o_imm        (disp_imm)
    );

    // arithmetic writes through port 1, logic through port 2
    warp_xrf xrf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_rdata(rs1_rdata),
        .o_rs2_rdata(rs2_rdata),
        .i_rd1_wen  (o_wb0_valid),
        .i_rd1_addr (o_wb0_rd),
        .i_rd1_wdata(o_wb0_data),
        .i_rd2_wen  (o_wb1_valid),
        .i_rd2_addr (o_wb1_rd),
        .i_rd2_wdata(o_wb1_data)
    );

    // both units share the dispatch payload and the two read ports
    warp_xarith xarith (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (arith_valid),
        .i_op      (disp_op),
        .i_rd      (disp_rd),
        .i_use_imm (disp_use_imm),
        .i_imm     (disp_imm),
        .i_rs1_data(rs1_rdata),
        .i_rs2_data(rs2_rdata),
        .o_valid   (o_wb0_valid),
        .o_rd      (o_wb0_rd),
        .o_result  (o_wb0_data)
    );

    warp_xlogic xlogic (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (logic_valid),
        .i_op      (disp_op),
        .i_rd      (disp_rd),
        .i_use_imm (disp_use_imm),
        .i_imm     (disp_imm),
        .i_rs1_data(rs1_rdata),
        .i_rs2_data(rs2_rdata),
        .o_valid   (o_wb1_valid),
        .o_rd      (o_wb1_rd),
        .o_result  (o_wb1_data)
    );

endmodule

/* src/warp_issue.sv */
`timescale 1ns/1ps

module warp_issue
    import warp_arch_pkg::*, warp_uop_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    output logic            o_ready,
    input  unit_sel_t       i_unit,
    input  logic [OP_W-1:0] i_op,
    input  reg_addr_t       i_rd,
    input  reg_addr_t       i_rs1,
    input  reg_addr_t       i_rs2,
    input  logic            i_use_imm,
    input  xdata_t          i_imm,
    input  logic            i_wb0_valid,
    input  reg_addr_t       i_wb0_rd,
    input  logic            i_wb1_valid,
    input  reg_addr_t       i_wb1_rd,
    output reg_addr_t       o_rs1_addr,
    output reg_addr_t       o_rs2_addr,
    output logic            o_arith_valid,
    output logic            o_logic_valid,
    output logic [OP_W-1:0] o_op,
    output reg_addr_t       o_rd,
    output logic            o_use_imm,
    output xdata_t          o_imm
);
    reg_mask_t busy;
    reg_mask_t set_mask;
    reg_mask_t retire0;
    reg_mask_t retire1;
    reg_mask_t in_flight;
    logic      hazard;
    logic      accept;

    // bit 0 of busy never gets set, so x0 never stalls anything
    assign hazard  = busy[i_rs1] | busy[i_rs2] | busy[i_rd];
    assign o_ready = !hazard;
    assign accept  = i_valid && o_ready;

    // sources go straight to the register file, data lands on the accepting edge
    assign o_rs1_addr = i_rs1;
    assign o_rs2_addr = i_rs2;

    assign set_mask = (accept && i_rd != '0) ? (reg_mask_t'(1) << i_rd) : '0;

    // retire masks from the writeback of each unit
    assign retire0 = (reg_mask_t'(1) << i_wb0_rd) & {NUM_REGS{i_wb0_valid}};
    assign retire1 = (reg_mask_t'(1) << i_wb1_rd) & {NUM_REGS{i_wb1_valid}};

    // destinations between dispatch and writeback, x0 excluded
    assign in_flight = (((reg_mask_t'(1) << o_rd) & {NUM_REGS{o_arith_valid | o_logic_valid}})
                       | retire0 | retire1) & ~reg_mask_t'(1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~(retire0 | retire1)) | set_mask;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_arith_valid <= 1'b0;
            o_logic_valid <= 1'b0;
        end else begin
            o_arith_valid <= accept && (i_unit == UNIT_ARITH);
            o_logic_valid <= accept && (i_unit == UNIT_LOGIC);
        end
    end

    // dispatch payload, only meaningful alongside a dispatch valid
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_op      <= i_op;
            o_rd      <= i_rd;
            o_use_imm <= i_use_imm;
            o_imm     <= i_imm;
        end
    end

    // an accepted micro-op never touches a register still in flight
    a_no_hazard_accept: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        accept |-> !(in_flight[i_rs1] || in_flight[i_rs2] || in_flight[i_rd])
    );

    // every nonzero writeback retires a register that issue marked busy
    a_wb_was_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_wb0_valid && i_wb0_rd != '0) |-> busy[i_wb0_rd]
    );

endmodule

/* src/warp_uop_pkg.sv */
package warp_uop_pkg;

    // width of the shared operation field
    localparam int OP_W = 3;

    // shift amount width, low bits of the second operand
    localparam int SHAMT_W = 6;

    // which execution unit takes the micro-op
    typedef enum logic {
        UNIT_ARITH = 1'b0,
        UNIT_LOGIC = 1'b1
    } unit_sel_t;

    // arithmetic unit operations, carried in the low two op bits
    typedef enum logic [1:0] {
        ARITH_ADD  = 2'd0,
        ARITH_SUB  = 2'd1,
        ARITH_SLT  = 2'd2,
        ARITH_SLTU = 2'd3
    } arith_op_t;

    // logic and shift unit operations
    typedef enum logic [2:0] {
        LOGIC_AND = 3'd0,
        LOGIC_OR  = 3'd1,
        LOGIC_XOR = 3'd2,
        LOGIC_SLL = 3'd3,
        LOGIC_SRL = 3'd4
    } logic_op_t;

endpackage

/* src/warp_xarith.sv */
`timescale 1ns/1ps

module warp_xarith
    import warp_arch_pkg::*, warp_uop_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic [OP_W-1:0] i_op,
    input  reg_addr_t       i_rd,
    input  logic            i_use_imm,
    input  xdata_t          i_imm,
    input  xdata_t          i_rs1_data,
    input  xdata_t          i_rs2_data,
    output logic            o_valid,
    output reg_addr_t       o_rd,
    output xdata_t          o_result
);
    arith_op_t op;
    xdata_t    op2;
    xdata_t    result;

    // only the low two bits carry an arithmetic operation
    assign op  = arith_op_t'(i_op[1:0]);
    assign op2 = i_use_imm ? i_imm : i_rs2_data;

    always_comb begin
        case (op)
            ARITH_ADD:  result = i_rs1_data + op2;
            ARITH_SUB:  result = i_rs1_data - op2;
            ARITH_SLT:  result = xdata_t'($signed(i_rs1_data) < $signed(op2));
            ARITH_SLTU: result = xdata_t'(i_rs1_data < op2);
            default:    result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_rd     <= i_rd;
            o_result <= result;
        end
    end

    a_valid_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_valid)
    );

endmodule

/* src/warp_xlogic.sv */
`timescale 1ns/1ps

module warp_xlogic
    import warp_arch_pkg::*, warp_uop_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic [OP_W-1:0] i_op,
    input  reg_addr_t       i_rd,
    input  logic            i_use_imm,
    input  xdata_t          i_imm,
    input  xdata_t          i_rs1_data,
    input  xdata_t          i_rs2_data,
    output logic            o_valid,
    output reg_addr_t       o_rd,
    output xdata_t          o_result
);
    logic_op_t          op;
    xdata_t             op2;
    logic [SHAMT_W-1:0] shamt;
    xdata_t             result;

    assign op    = logic_op_t'(i_op);
    assign op2   = i_use_imm ? i_imm : i_rs2_data;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (op)
            LOGIC_AND: result = i_rs1_data & op2;
            LOGIC_OR:  result = i_rs1_data | op2;
            LOGIC_XOR: result = i_rs1_data ^ op2;
            LOGIC_SLL: result = i_rs1_data << shamt;
            // logical, zeros shift in from the top
            LOGIC_SRL: result = i_rs1_data >> shamt;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_rd     <= i_rd;
            o_result <= result;
        end
    end

endmodule

/* src/warp_xrf.sv */
`timescale 1ns/1ps

module warp_xrf
    import warp_arch_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    output xdata_t    o_rs1_rdata,
    output xdata_t    o_rs2_rdata,
    input  logic      i_rd1_wen,
    input  reg_addr_t i_rd1_addr,
    input  xdata_t    i_rd1_wdata,
    input  logic      i_rd2_wen,
    input  reg_addr_t i_rd2_addr,
    input  xdata_t    i_rd2_wdata
);
    // x1 .. x31, x0 has no storage
    xdata_t regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_rd1_wen && i_rd1_addr != '0) begin
                regs[i_rd1_addr] <= i_rd1_wdata;
            end
            if (i_rd2_wen && i_rd2_addr != '0) begin
                regs[i_rd2_addr] <= i_rd2_wdata;
            end
        end
    end

    // synchronous reads, x0 returns zero
    always_ff @(posedge i_clk) begin
        o_rs1_rdata <= (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
        o_rs2_rdata <= (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];
    end

    // the scoreboard keeps both units off the same destination
    a_no_write_clash: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_rd1_wen && i_rd2_wen && i_rd1_addr != '0) |-> (i_rd1_addr != i_rd2_addr)
    );

endmodule

/* test/tb_warp_backend.sv */
`timescale 1ns/1ps

module tb_warp_backend
    import warp_arch_pkg::*, warp_uop_pkg::*;
();
    localparam int MAX_WAIT = 50;

    logic            i_clk;
    logic            i_rst_n;
    logic            i_valid;
    logic            o_ready;
    unit_sel_t       i_unit;
    logic [OP_W-1:0] i_op;
    reg_addr_t       i_rd;
    reg_addr_t       i_rs1;
    reg_addr_t       i_rs2;
    logic            i_use_imm;
    xdata_t          i_imm;
    logic            o_wb0_valid;
    reg_addr_t       o_wb0_rd;
    xdata_t          o_wb0_data;
    logic            o_wb1_valid;
    reg_addr_t       o_wb1_rd;
    xdata_t          o_wb1_data;

    // one entry per line of the cases file
    string  case_name [$];
    int     case_unit [$];
    int     case_op [$];
    int     case_rd [$];
    int     case_rs1 [$];
    int     case_rs2 [$];
    int     case_use_imm [$];
    xdata_t case_imm [$];
    xdata_t case_exp [$];

    // accepted cases still waiting for their writeback
    int arith_q [$];
    int logic_q [$];

    int cur = 0;
    int pass_count = 0;
    int fail_count = 0;
    int error_count = 0;
    bit aborted = 0;

    warp_backend dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic compare_value(input string name, input string what, input xdata_t exp,
                                 input xdata_t act, inout bit ok);
        if (exp !== act) begin
            $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic load_cases();
        int     fd;
        int     n;
        int     f [6];
        string  line;
        string  name;
        xdata_t imm;
        xdata_t exp;
        fd = $fopen("test/warp_backend_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the cases file could not be opened");
            error_count++;
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comment and blank lines
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %h %h", name,
                                f[0], f[1], f[2], f[3], f[4], f[5], imm, exp);
                    if (n == 9) begin
                        case_name.push_back(name);
                        case_unit.push_back(f[0]);
                        case_op.push_back(f[1]);
                        case_rd.push_back(f[2]);
                        case_rs1.push_back(f[3]);
                        case_rs2.push_back(f[4]);
                        case_use_imm.push_back(f[5]);
                        case_imm.push_back(imm);
                        case_exp.push_back(exp);
                    end else begin
                        $display("ERROR: a line of the cases file could not be parsed");
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic drive_case(input int idx);
        int waited;
        cur       = idx;
        i_valid   = 1'b1;
        i_unit    = unit_sel_t'(case_unit[idx]);
        i_op      = OP_W'(case_op[idx]);
        i_rd      = reg_addr_t'(case_rd[idx]);
        i_rs1     = reg_addr_t'(case_rs1[idx]);
        i_rs2     = reg_addr_t'(case_rs2[idx]);
        i_use_imm = case_use_imm[idx][0];
        i_imm     = case_imm[idx];
        waited    = 0;
        #1;
        while (!o_ready && waited < MAX_WAIT) begin
            @(negedge i_clk);
            #1;
            waited++;
        end
        if (!o_ready) begin
            $display("ERROR: %s was never accepted, issue stayed stalled", case_name[idx]);
            error_count++;
            aborted = 1'b1;
            i_valid = 1'b0;
        end else begin
            @(posedge i_clk);
            @(negedge i_clk);
            i_valid = 1'b0;
        end
    endtask

    task automatic check_writeback(input int unit, input reg_addr_t rd, input xdata_t data);
        int idx;
        bit ok;
        ok = 1'b1;
        if ((unit == 0 && arith_q.size() == 0) || (unit == 1 && logic_q.size() == 0)) begin
            $display("ERROR: writeback on port %0d with no micro-op in flight", unit);
            error_count++;
        end else begin
            if (unit == 0) begin
                idx = arith_q.pop_front();
            end else begin
                idx = logic_q.pop_front();
            end
            compare_value(case_name[idx], "rd", xdata_t'(case_rd[idx]), xdata_t'(rd), ok);
            // data written to x0 is discarded anyway
            if (case_rd[idx] != 0) begin
                compare_value(case_name[idx], "data", case_exp[idx], data, ok);
            end
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("%s: %s", case_name[idx], ok ? "ok" : "mismatch");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((arith_q.size() != 0 || logic_q.size() != 0) && waited < MAX_WAIT) begin
            @(negedge i_clk);
            #1;
            waited++;
        end
        if (arith_q.size() != 0 || logic_q.size() != 0) begin
            $display("ERROR: accepted micro-ops never wrote back");
            error_count++;
        end
        // a few idle cycles catch a duplicated writeback
        repeat (4) @(negedge i_clk);
    endtask

    task automatic report_and_finish();
        if (pass_count + fail_count != case_name.size() || case_name.size() == 0) begin
            $display("ERROR: not every case produced exactly one writeback");
            error_count++;
        end
        $display("tests passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // acceptance is sampled before the edge updates the scoreboard
    always @(posedge i_clk) begin
        if (i_rst_n && i_valid && o_ready) begin
            if (i_unit == UNIT_ARITH) begin
                arith_q.push_back(cur);
            end else begin
                logic_q.push_back(cur);
            end
        end
    end

    always @(negedge i_clk) begin
        if (i_rst_n && o_wb0_valid === 1'b1) begin
            check_writeback(0, o_wb0_rd, o_wb0_data);
        end
        if (i_rst_n && o_wb1_valid === 1'b1) begin
            check_writeback(1, o_wb1_rd, o_wb1_data);
        end
    end

    initial begin
        bit ok;
        i_rst_n   = 1'b0;
        i_valid   = 1'b0;
        i_unit    = UNIT_ARITH;
        i_op      = '0;
        i_rd      = '0;
        i_rs1     = '0;
        i_rs2     = '0;
        i_use_imm = 1'b0;
        i_imm     = '0;
        load_cases();
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        // idle pipeline right after reset
        ok = 1'b1;
        repeat (3) begin
            compare_value("reset_idle", "wb0_valid", '0, xdata_t'(o_wb0_valid), ok);
            compare_value("reset_idle", "wb1_valid", '0, xdata_t'(o_wb1_valid), ok);
            compare_value("reset_idle", "ready", 64'd1, xdata_t'(o_ready), ok);
            @(negedge i_clk);
        end
        if (!ok) begin
            error_count++;
        end
        $display("reset_idle: %s", ok ? "ok" : "mismatch");
        for (int i = 0; i < case_name.size() && !aborted; i++) begin
            drive_case(i);
        end
        if (!aborted) begin
            drain();
        end
        report_and_finish();
    end

endmodule

/* test/warp_backend_cases.txt */
# name unit(0 arith, 1 logic) op rd rs1 rs2 use_imm, all decimal, then imm and expected in hex
# expected values follow program order from an all-zero register file, x0 data is ignored
reset_add_imm 0 0 1 0 0 1 0000000000001234 0000000000001234
add_imm_neg 0 0 2 0 0 1 fffffffffffffff0 fffffffffffffff0
sub_wrap 0 1 5 0 1 0 0000000000000000 ffffffffffffedcc
slt_neg 0 2 6 2 1 0 0000000000000000 0000000000000001
and_imm 1 0 9 2 0 1 00000000000000ff 00000000000000f0
or_reg 1 1 10 1 9 0 0000000000000000 00000000000012f4
xor_imm 1 2 11 1 0 1 ffffffffffffffff ffffffffffffedcb
sll_0 1 3 12 1 0 1 0000000000000000 0000000000001234
sll_1 1 3 13 1 0 1 0000000000000001 0000000000002468
sll_63 1 3 14 6 0 1 000000000000003f 8000000000000000
srl_0 1 4 15 2 0 1 0000000000000000 fffffffffffffff0
srl_1 1 4 16 2 0 1 0000000000000001 7ffffffffffffff8
srl_63 1 4 17 2 0 1 000000000000003f 0000000000000001
alt_add 0 0 18 1 0 1 0000000000000001 0000000000001235
alt_xor_reg 1 2 19 1 9 0 0000000000000000 00000000000012c4
alt_sub 0 1 20 1 9 0 0000000000000000 0000000000001144
alt_and_reg 1 0 21 2 5 0 0000000000000000 ffffffffffffedc0
alt_sltu 0 3 22 1 2 0 0000000000000000 0000000000000001
alt_or_imm 1 1 23 9 0 1 00000000000f0000 00000000000f00f0
chain_a 0 0 24 0 0 1 0000000000000005 0000000000000005
chain_b 0 0 24 24 24 0 0000000000000000 000000000000000a
chain_c 1 3 25 24 0 1 0000000000000002 0000000000000028
chain_d 0 1 26 25 24 0 0000000000000000 000000000000001e
x0_write 0 0 0 1 0 1 00000000000000ff 0000000000000000
x0_read_reg 1 1 27 0 0 0 0000000000000000 0000000000000000
x0_read_imm 0 0 28 0 0 1 0000000000000007 0000000000000007
